// File: build.f
verilog/isa_pkg.sv
verilog/bus_pkg.sv
verilog/cpu_decode.sv
verilog/cpu_execute.sv
verilog/cpu_result.sv
verilog/wb_data_port.sv
verilog/cpu_top.sv
+incdir+testbench
testbench/tb_cpu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the CPU testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log

verilator --binary --timing -f build.f --top-module tb_cpu -o tb_cpu_sim > build.log 2>&1 \
    && ./obj_dir/tb_cpu_sim > sim.log 2>&1 \
    || echo "Build or simulation stopped early, see build.log and sim.log"

touch sim.log
grep -q "^Everything OK$" sim.log \
    && { echo "PASS"; exit 0; } \
    || { echo "FAIL"; exit 1; }

// File: testbench/tb_cpu_model.svh
`ifndef TB_CPU_MODEL_SVH
`define TB_CPU_MODEL_SVH

instr_t     rom [0:255];            // Program ROM image
int         prog_len;
int         halt_pc;                // Jump-to-self that ends the program
logic [7:0] model_mem [0:65535];    // Expected data memory
logic [7:0] exp_out [$];            // Expected output bytes in order

function automatic instr_t mk(alu_op_e op, target_e t, a_src_e a, b_src_e b, cond_e c,
                              logic dir, logic [7:0] imm, logic [15:0] adr);
    instr_t w;
    w = '0;
    w.alu_op        = op;
    w.target        = t;
    w.a_src         = a;
    w.b_src         = b;
    w.cond          = c;
    w.addr_direct   = dir;
    w.immed8        = imm;
    w.direct_addr16 = adr;
    return w;
endfunction

function automatic void put(instr_t w);
    rom[prog_len] = w;
    prog_len      = prog_len + 1;
endfunction

// Signed range test for an 8-bit result
function automatic logic out_of_range(int v);
    return (v > 127) || (v < -128);
endfunction

// Runs the ROM program on model state, fills exp_out and model_mem, returns the step count
function automatic int run_model();
    logic [7:0]  r [4];
    logic [15:0] m;
    flags_t      f;
    instr_t      w;
    int          pc;
    int          steps;
    int          a;
    int          b;
    int          cin;
    int          s;
    int          sa;
    int          sb;
    logic [7:0]  y;
    logic [15:0] ad;
    logic        c_o;
    logic        o_o;
    logic        take;
    for (int i = 0; i < 4; i++) r[i] = 8'd0;
    m     = 16'd0;
    f     = '0;
    pc    = 0;
    steps = 0;
    while (steps < 20000) begin
        w     = rom[pc];
        steps = steps + 1;
        if (w.target == t_jump && w.cond == cond_always && int'(w.direct_addr16) == pc) begin
            break;                                  // Halt word
        end
        ad = w.addr_direct ? w.direct_addr16 : m;
        case (w.a_src)
            a_marlo: a = int'(m[7:0]);
            a_marhi: a = int'(m[15:8]);
            default: a = int'(r[w.a_src[1:0]]);
        endcase
        case (w.b_src)
            b_immed: b = int'(w.immed8);
            b_ram:   b = int'(model_mem[ad]);
            b_marlo: b = int'(m[7:0]);
            b_marhi: b = int'(m[15:8]);
            default: b = int'(r[w.b_src[1:0]]);
        endcase
        cin = f.c ? 1 : 0;
        sa  = (a > 127) ? a - 256 : a;
        sb  = (b > 127) ? b - 256 : b;
        c_o = 1'b0;
        o_o = 1'b0;
        case (w.alu_op)
            pass_a: s = a;
            pass_b: s = b;
            add: begin
                s   = a + b;
                c_o = s > 255;
                o_o = out_of_range(sa + sb);
            end
            addc: begin
                s   = a + b + cin;
                c_o = s > 255;
                o_o = out_of_range(sa + sb + cin);
            end
            sub: begin
                s   = a - b;
                c_o = s < 0;
                o_o = out_of_range(sa - sb);
            end
            subc: begin
                s   = a - b - cin;
                c_o = s < 0;
                o_o = out_of_range(sa - sb - cin);
            end
            and_op: s = a & b;
            or_op:  s = a | b;
            xor_op: s = a ^ b;
            not_a:  s = 255 - a;
            shl: begin
                s   = a * 2;
                c_o = a >= 128;
            end
            shr: begin
                s   = a / 2;
                c_o = (a % 2) == 1;
            end
            inc_a: begin
                s   = a + 1;
                c_o = s > 255;
            end
            dec_a: begin
                s   = a - 1;
                c_o = s < 0;
            end
            default: s = 0;
        endcase
        y = 8'(s & 255);
        if (w.target == t_jump) begin
            case (w.cond)
                cond_always: take = 1'b1;
                cond_c:      take = f.c;
                cond_z:      take = f.z;
                cond_n:      take = f.n;
                cond_o:      take = f.o;
                cond_eq:     take = f.eq;
                cond_ne:     take = f.ne;
                cond_gt:     take = f.gt;
                cond_lt:     take = f.lt;
                default:     take = 1'b0;
            endcase
            pc = take ? int'(w.direct_addr16) : pc + 1;   // Flags untouched
        end else begin
            f.c  = c_o;
            f.z  = (y == 8'd0);
            f.o  = o_o;
            f.n  = y[7];
            f.gt = a > b;
            f.lt = a < b;
            f.eq = a == b;
            f.ne = a != b;
            case (w.target)
                t_rega, t_regb, t_regc, t_regd: r[w.target[1:0]] = y;
                t_marlo: m[7:0] = y;
                t_marhi: m[15:8] = y;
                t_ram:   model_mem[ad] = y;
                t_out:   exp_out.push_back(y);
                default: ;
            endcase
            pc = pc + 1;
        end
    end
    return steps;
endfunction

`endif

// File: testbench/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu
    import isa_pkg::*, bus_pkg::*;
();

    logic            clk;
    logic            reset;
    logic [PC_W-1:0] instr_addr;
    instr_t          instr_data;
    wb_req_t         wb_req;
    wb_rsp_t         wb_rsp;
    out_t            out_port;

    logic [7:0] ram [0:65535];      // Wishbone slave memory
    int         cycles;
    int         cycle_limit;
    int         out_idx;
    int         steps;
    logic       armed;              // Slave counting down an ack delay
    int         ack_cnt;
    wb_req_t    prev_req;
    logic       prev_wait;          // Last cycle had cyc without ack

    `include "tb_cpu_model.svh"

    cpu_top cpu_top_i (
        .clk        (clk),
        .reset      (reset),
        .instr_addr (instr_addr),
        .instr_data (instr_data),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .out_port   (out_port)
    );

    always #2 clk = ~clk;           // 4 ns period

    task automatic fail_now();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_out(string name, out_t got, out_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_ram(logic [15:0] adr, logic [7:0] got, logic [7:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: ram[%h] got %h expected %h", $time, adr, got, exp);
            fail_now();
        end
    endtask

    task automatic check_bus(string name, wb_req_t got, wb_req_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
            fail_now();
        end
    endtask

    // Test programs, one after another in the ROM
    task automatic build_programs();
        int tgt;
        int loop_top;
        logic [7:0] cmp_val [3];
        cmp_val[0] = 8'h10;
        cmp_val[1] = 8'h5a;
        cmp_val[2] = 8'hc0;
        prog_len = 0;
        // Every ALU op on register and immediate operands
        put(mk(pass_b, t_rega, a_rega, b_immed, cond_always, 1'b0, 8'h5a, 16'h0));
        put(mk(pass_b, t_regb, a_rega, b_immed, cond_always, 1'b0, 8'hc3, 16'h0));
        for (int k = 0; k < 14; k++) begin
            put(mk(alu_op_e'(k), t_out, a_rega, b_regb, cond_always, 1'b0, 8'h0, 16'h0));
            put(mk(alu_op_e'(k), t_out, a_regb, b_immed, cond_always, 1'b0, 8'h81, 16'h0));
        end
        // Compare, conditional jump, then addc shows the carry the jump left alone
        for (int c = 0; c < 9; c++) begin
            for (int v = 0; v < 3; v++) begin
                put(mk(sub, t_none, a_rega, b_immed, cond_always, 1'b0, cmp_val[v], 16'h0));
                tgt = prog_len + 2;
                put(mk(pass_a, t_jump, a_rega, b_immed, cond_e'(c), 1'b0, 8'h0, 16'(tgt)));
                put(mk(pass_b, t_out, a_rega, b_immed, cond_always, 1'b0, 8'hee, 16'h0));
                put(mk(addc, t_out, a_rega, b_immed, cond_always, 1'b0, 8'h00, 16'h0));
            end
        end
        // Direct store and load
        put(mk(pass_b, t_ram, a_rega, b_immed, cond_always, 1'b1, 8'h3c, 16'h1234));
        put(mk(add, t_ram, a_rega, b_regb, cond_always, 1'b1, 8'h0, 16'hfffe));
        put(mk(pass_b, t_out, a_rega, b_ram, cond_always, 1'b1, 8'h0, 16'h1234));
        put(mk(add, t_out, a_rega, b_ram, cond_always, 1'b1, 8'h0, 16'hfffe));
        put(mk(pass_b, t_out, a_rega, b_ram, cond_always, 1'b1, 8'h0, 16'h0777));
        // MAR addressing with MAR halves made by the ALU
        put(mk(add, t_marhi, a_regb, b_immed, cond_always, 1'b0, 8'hbd, 16'h0));
        put(mk(pass_b, t_marlo, a_rega, b_immed, cond_always, 1'b0, 8'h21, 16'h0));
        put(mk(xor_op, t_ram, a_rega, b_regb, cond_always, 1'b0, 8'h0, 16'h0));
        put(mk(pass_b, t_out, a_rega, b_ram, cond_always, 1'b0, 8'h0, 16'h0));
        put(mk(inc_a, t_marlo, a_marlo, b_immed, cond_always, 1'b0, 8'h0, 16'h0));
        put(mk(pass_b, t_ram, a_rega, b_marhi, cond_always, 1'b0, 8'h0, 16'h0));
        put(mk(pass_b, t_out, a_rega, b_ram, cond_always, 1'b0, 8'h0, 16'h0));
        put(mk(pass_b, t_out, a_rega, b_marlo, cond_always, 1'b0, 8'h0, 16'h0));
        // Count down loop
        put(mk(pass_b, t_regc, a_rega, b_immed, cond_always, 1'b0, 8'h05, 16'h0));
        loop_top = prog_len;
        put(mk(pass_a, t_out, a_regc, b_immed, cond_always, 1'b0, 8'h0, 16'h0));
        put(mk(dec_a, t_regc, a_regc, b_immed, cond_always, 1'b0, 8'h0, 16'h0));
        put(mk(pass_a, t_none, a_regc, b_immed, cond_always, 1'b0, 8'h00, 16'h0));
        put(mk(pass_a, t_jump, a_rega, b_immed, cond_ne, 1'b0, 8'h0, 16'(loop_top)));
        halt_pc = prog_len;
        put(mk(pass_a, t_jump, a_rega, b_immed, cond_always, 1'b0, 8'h0, 16'(halt_pc)));
    endtask

    // Synchronous program ROM, one cycle latency
    always @(posedge clk) begin
        instr_data <= rom[instr_addr[7:0]];
    end

    // Wishbone slave with 0 to 3 extra wait cycles
    always @(posedge clk) begin
        if (reset) begin
            wb_rsp <= '0;
            armed  <= 1'b0;
        end else if (wb_rsp.ack) begin
            wb_rsp.ack <= 1'b0;
        end else if (wb_req.cyc && wb_req.stb) begin
            if (!armed) begin
                ack_cnt = int'($urandom % 4);
                armed <= 1'b1;
            end else begin
                ack_cnt = ack_cnt - 1;
            end
            if (ack_cnt == 0) begin
                armed      <= 1'b0;
                wb_rsp.ack <= 1'b1;
                if (wb_req.we) begin
                    ram[wb_req.adr] <= wb_req.dat;
                end else begin
                    wb_rsp.dat <= ram[wb_req.adr];
                end
            end
        end
    end

    // Output bytes and bus stability against the model
    always @(posedge clk) begin
        out_t exp_o;
        if (reset) begin
            prev_wait <= 1'b0;
        end else begin
            if (out_port.valid) begin
                if (out_idx >= exp_out.size()) begin
                    $display("More output bytes came than the model produced");
                    fail_now();
                end
                exp_o.valid = 1'b1;
                exp_o.data  = exp_out[out_idx];
                check_out("out_port", out_port, exp_o);
                out_idx = out_idx + 1;
            end
            if (prev_wait) begin
                check_bus("wb_req", wb_req, prev_req);
            end
            prev_wait <= wb_req.cyc && !wb_rsp.ack;
            prev_req  <= wb_req;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Run did not finish within %0d cycles", cycle_limit);
            fail_now();
        end
    end

    initial begin
        wb_req_t idle_req;
        out_t    idle_out;
        clk        = 1'b0;
        reset      <= 1'b1;
        wb_rsp     <= '0;
        instr_data <= '0;
        cycles     = 0;
        out_idx    = 0;
        void'($urandom(70));                    // Seed for the ack delays
        for (int i = 0; i < 65536; i++) begin
            ram[i]       = 8'(i[7:0] ^ (i[15:8] * 3) ^ 8'h5a);   // Fill depends on all bits
            model_mem[i] = ram[i];
        end
        for (int i = 0; i < 256; i++) rom[i] = '0;
        build_programs();
        steps = run_model();
        cycle_limit = 16 + 5 * steps * 4;       // Worst bus latency is 4 cycles
        repeat (16) @(posedge clk);
        idle_req     = wb_req;
        idle_req.cyc = 1'b0;
        idle_req.stb = 1'b0;
        check_bus("wb_req after reset", wb_req, idle_req);
        idle_out       = out_port;
        idle_out.valid = 1'b0;
        check_out("out_port after reset", out_port, idle_out);
        reset <= 1'b0;
        // Halt reached with every byte seen
        while (!(out_idx == exp_out.size() && instr_addr == 16'(halt_pc) && !wb_req.cyc)) begin
            @(posedge clk);
        end
        repeat (8) @(posedge clk);
        for (int i = 0; i < 65536; i++) begin
            check_ram(16'(i), ram[i], model_mem[i]);
        end
        $display("Everything OK");
        $finish;
    end

endmodule

// File: verilog/cpu_top.sv
`timescale 1ns/1ps

module cpu_top
    import isa_pkg::*, bus_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    output logic [PC_W-1:0] instr_addr,     // Program ROM address
    input  instr_t          instr_data,     // ROM answer one cycle later
    output wb_req_t         wb_req,
    input  wb_rsp_t         wb_rsp,
    output out_t            out_port
);

    instr_t     instr;
    logic       exec_en;
    logic       fetch_en;
    mem_cmd_t   mem_cmd;
    logic       mem_done;
    logic [7:0] rd_data;    // Last read byte
    logic [7:0] alu_y;
    flags_t     flags;
    logic [7:0] rd_a;
    logic [7:0] rd_b;
    logic [15:0] mar;

    // Sequencer and instruction latch
    cpu_decode cpu_decode_i (
        .clk        (clk),
        .reset      (reset),
        .instr_data (instr_data),
        .mem_done   (mem_done),
        .mar        (mar),
        .wr_data    (alu_y),
        .instr      (instr),
        .exec_en    (exec_en),
        .mem_cmd    (mem_cmd),
        .fetch_en   (fetch_en)
    );

    cpu_execute cpu_execute_i (
        .clk      (clk),
        .reset    (reset),
        .instr    (instr),
        .exec_en  (exec_en),
        .rd_a     (rd_a),
        .rd_b     (rd_b),
        .mar      (mar),
        .ram_data (rd_data),
        .alu_y    (alu_y),
        .flags    (flags)
    );

    // Writeback side
    cpu_result cpu_result_i (
        .clk      (clk),
        .reset    (reset),
        .instr    (instr),
        .exec_en  (exec_en),
        .fetch_en (fetch_en),
        .alu_y    (alu_y),
        .flags    (flags),
        .rd_a     (rd_a),
        .rd_b     (rd_b),
        .mar      (mar),
        .pc       (instr_addr),
        .out_port (out_port)
    );

    wb_data_port wb_data_port_i (
        .clk      (clk),
        .reset    (reset),
        .mem_cmd  (mem_cmd),
        .wb_rsp   (wb_rsp),
        .wb_req   (wb_req),
        .mem_done (mem_done),
        .rd_data  (rd_data)
    );

endmodule

// File: verilog/wb_data_port.sv
`timescale 1ns/1ps

module wb_data_port
    import bus_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  mem_cmd_t         mem_cmd,
    input  wb_rsp_t          wb_rsp,
    output wb_req_t          wb_req,
    output logic             mem_done,
    output logic [DAT_W-1:0] rd_data
);

    typedef enum logic {
        wb_idle,
        wb_busy
    } state_e;

    state_e           state;
    logic             we_q;
    logic [ADR_W-1:0] adr_q;
    logic [DAT_W-1:0] dat_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= wb_idle;
        end else begin
            case (state)
                wb_idle: begin
                    if (mem_cmd.start) begin
                        state <= wb_busy;
                    end
                end
                wb_busy: begin
                    if (wb_rsp.ack) begin
                        state <= wb_idle;   // cyc and stb drop next cycle
                    end
                end
                default: state <= wb_idle;
            endcase
        end
    end

    // Request fields frozen until ack
    always_ff @(posedge clk) begin
        if ((state == wb_idle) && mem_cmd.start) begin
            we_q  <= mem_cmd.we;
            adr_q <= mem_cmd.adr;
            dat_q <= mem_cmd.dat;
        end
    end

    // Read byte taken on the ack cycle
    always_ff @(posedge clk) begin
        if ((state == wb_busy) && wb_rsp.ack && !we_q) begin
            rd_data <= wb_rsp.dat;
        end
    end

    assign mem_done = (state == wb_busy) && wb_rsp.ack;    // One pulse per transfer

    always_comb begin
        wb_req.cyc = (state == wb_busy);
        wb_req.stb = (state == wb_busy);
        wb_req.we  = we_q;
        wb_req.adr = adr_q;
        wb_req.dat = dat_q;
    end

endmodule

// File: verilog/cpu_result.sv
`timescale 1ns/1ps

module cpu_result
    import isa_pkg::*, bus_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  instr_t          instr,
    input  logic            exec_en,
    input  logic            fetch_en,
    input  logic [7:0]      alu_y,
    input  flags_t          flags,
    output logic [7:0]      rd_a,
    output logic [7:0]      rd_b,
    output logic [15:0]     mar,
    output logic [PC_W-1:0] pc,
    output out_t            out_port
);

    logic [3:0][7:0] regs;      // rega to regd
    logic [7:0]      marlo;
    logic [7:0]      marhi;
    logic            reg_we;
    logic            cond_ok;

    // Two read ports, only meaningful when the source is a register
    assign rd_a = regs[instr.a_src[1:0]];
    assign rd_b = regs[instr.b_src[1:0]];

    assign reg_we = exec_en && (instr.target inside {t_rega, t_regb, t_regc, t_regd});

    always_ff @(posedge clk) begin
        if (reset) begin
            regs <= '0;
        end else if (reg_we) begin
            regs[instr.target[1:0]] <= alu_y;
        end
    end

    // MAR halves written like any other target
    always_ff @(posedge clk) begin
        if (reset) begin
            marlo <= 8'd0;
            marhi <= 8'd0;
        end else if (exec_en) begin
            if (instr.target == t_marlo) begin
                marlo <= alu_y;
            end
            if (instr.target == t_marhi) begin
                marhi <= alu_y;
            end
        end
    end

    assign mar = {marhi, marlo};

    // Condition test on the stored flags
    always_comb begin
        case (instr.cond)
            cond_always: cond_ok = 1'b1;
            cond_c:      cond_ok = flags.c;
            cond_z:      cond_ok = flags.z;
            cond_n:      cond_ok = flags.n;
            cond_o:      cond_ok = flags.o;
            cond_eq:     cond_ok = flags.eq;
            cond_ne:     cond_ok = flags.ne;
            cond_gt:     cond_ok = flags.gt;
            cond_lt:     cond_ok = flags.lt;
            default:     cond_ok = 1'b0;
        endcase
    end

    // PC steps past the word on the fetch edge, the ROM has sampled the old value
    // A taken jump overwrites it in exec
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (fetch_en) begin
            pc <= pc + 1'b1;
        end else if (exec_en && (instr.target == t_jump) && cond_ok) begin
            pc <= instr.direct_addr16;
        end
    end

    // Output strobe lasts the single exec cycle
    assign out_port.valid = exec_en && (instr.target == t_out);
    assign out_port.data  = alu_y;

endmodule

// File: verilog/cpu_execute.sv
`timescale 1ns/1ps

module cpu_execute
    import isa_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  instr_t      instr,
    input  logic        exec_en,
    input  logic [7:0]  rd_a,
    input  logic [7:0]  rd_b,
    input  logic [15:0] mar,
    input  logic [7:0]  ram_data,   // Captured on the read ack
    output logic [7:0]  alu_y,
    output flags_t      flags
);

    logic [7:0] op_a;
    logic [7:0] op_b;
    logic [8:0] res;        // Bit 8 is carry or borrow
    logic       ovf;
    flags_t     flags_nxt;

    always_comb begin
        case (instr.a_src)
            a_marlo: op_a = mar[7:0];
            a_marhi: op_a = mar[15:8];
            default: op_a = rd_a;           // rega to regd
        endcase
    end

    always_comb begin
        case (instr.b_src)
            b_immed: op_b = instr.immed8;
            b_ram:   op_b = ram_data;
            b_marlo: op_b = mar[7:0];
            b_marhi: op_b = mar[15:8];
            default: op_b = rd_b;
        endcase
    end

    always_comb begin
        case (instr.alu_op)
            pass_a:  res = {1'b0, op_a};
            pass_b:  res = {1'b0, op_b};
            add:     res = {1'b0, op_a} + {1'b0, op_b};
            addc:    res = {1'b0, op_a} + {1'b0, op_b} + {8'd0, flags.c};
            sub:     res = {1'b0, op_a} - {1'b0, op_b};     // Wraps to set bit 8 on borrow
            subc:    res = {1'b0, op_a} - {1'b0, op_b} - {8'd0, flags.c};
            and_op:  res = {1'b0, op_a & op_b};
            or_op:   res = {1'b0, op_a | op_b};
            xor_op:  res = {1'b0, op_a ^ op_b};
            not_a:   res = {1'b0, ~op_a};
            shl:     res = {op_a, 1'b0};
            shr:     res = {op_a[0], 1'b0, op_a[7:1]};
            inc_a:   res = {1'b0, op_a} + 9'd1;
            dec_a:   res = {1'b0, op_a} - 9'd1;
            default: res = 9'd0;
        endcase
    end

    // Signed overflow for add and sub only
    always_comb begin
        case (instr.alu_op)
            add, addc: ovf = (op_a[7] == op_b[7]) && (res[7] != op_a[7]);
            sub, subc: ovf = (op_a[7] != op_b[7]) && (res[7] != op_a[7]);
            default:   ovf = 1'b0;
        endcase
    end

    always_comb begin
        flags_nxt.c  = res[8];
        flags_nxt.z  = (res[7:0] == 8'd0);
        flags_nxt.o  = ovf;
        flags_nxt.n  = res[7];
        flags_nxt.gt = (op_a > op_b);      // Unsigned compare of the operands
        flags_nxt.lt = (op_a < op_b);
        flags_nxt.eq = (op_a == op_b);
        flags_nxt.ne = (op_a != op_b);
    end

    // Jumps leave the flags for the next instruction
    always_ff @(posedge clk) begin
        if (reset) begin
            flags <= '0;
        end else if (exec_en && (instr.target != t_jump)) begin
            flags <= flags_nxt;
        end
    end

    assign alu_y = res[7:0];

endmodule

// File: verilog/cpu_decode.sv
`timescale 1ns/1ps

module cpu_decode
    import isa_pkg::*, bus_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  instr_t      instr_data,     // ROM word, valid during decode
    input  logic        mem_done,
    input  logic [15:0] mar,
    input  logic [7:0]  wr_data,        // ALU result for stores
    output instr_t      instr,
    output logic        exec_en,
    output mem_cmd_t    mem_cmd,
    output logic        fetch_en
);

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_memrd,
        st_exec,
        st_memwr
    } state_e;

    state_e state;
    state_e state_nxt;
    instr_t instr_q;
    instr_t instr_sel;      // Word that owns the memory access this cycle
    logic   rd_go;
    logic   wr_go;

    // Instruction latch, loaded once per instruction
    always_ff @(posedge clk) begin
        if (state == st_decode) begin
            instr_q <= instr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_fetch;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_fetch: begin
                state_nxt = st_decode;      // ROM samples pc on this edge
            end
            st_decode: begin
                if (instr_data.b_src == b_ram) begin
                    state_nxt = st_memrd;
                end else begin
                    state_nxt = st_exec;
                end
            end
            st_memrd: begin
                if (mem_done) begin
                    state_nxt = st_exec;    // Read byte now captured
                end
            end
            st_exec: begin
                if (instr_q.target == t_ram) begin
                    state_nxt = st_memwr;
                end else begin
                    state_nxt = st_fetch;
                end
            end
            st_memwr: begin
                if (mem_done) begin
                    state_nxt = st_fetch;
                end
            end
            default: state_nxt = st_fetch;
        endcase
    end

    // Read is launched while the word is still on the ROM port
    assign rd_go = (state == st_decode) && (instr_data.b_src == b_ram);
    // Store data is the ALU result of the exec cycle
    assign wr_go = (state == st_exec) && (instr_q.target == t_ram);
    assign instr_sel = (state == st_decode) ? instr_data : instr_q;

    always_comb begin
        mem_cmd.start = rd_go || wr_go;
        mem_cmd.we    = wr_go;
        // Direct or register addressing
        mem_cmd.adr   = instr_sel.addr_direct ? instr_sel.direct_addr16 : mar;
        mem_cmd.dat   = wr_data;
    end

    assign instr    = instr_q;
    assign exec_en  = (state == st_exec);
    assign fetch_en = (state == st_fetch);

endmodule

// File: verilog/bus_pkg.sv
package bus_pkg;

    localparam int ADR_W = 16;  // Data memory address
    localparam int DAT_W = 8;   // Data memory byte

    // Wishbone classic master side
    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [ADR_W-1:0] adr;
        logic [DAT_W-1:0] dat;
    } wb_req_t;

    // Wishbone slave side
    typedef struct packed {
        logic             ack;
        logic [DAT_W-1:0] dat;
    } wb_rsp_t;

    // One byte per valid cycle
    typedef struct packed {
        logic             valid;
        logic [DAT_W-1:0] data;
    } out_t;

    // Single-cycle launch from the sequencer
    typedef struct packed {
        logic             start;
        logic             we;
        logic [ADR_W-1:0] adr;
        logic [DAT_W-1:0] dat;
    } mem_cmd_t;

endpackage

// File: verilog/isa_pkg.sv
package isa_pkg;

    localparam int INSTR_W = 48;    // One program ROM word
    localparam int PC_W    = 16;    // Program counter and ROM address width

    // ALU operations
    typedef enum logic [3:0] {
        pass_a,
        pass_b,
        add,
        addc,       // Carry-in from stored c
        sub,        // c holds the borrow out
        subc,
        and_op,
        or_op,
        xor_op,
        not_a,
        shl,        // Bit shifted out lands in c
        shr,
        inc_a,
        dec_a
    } alu_op_e;

    // Register targets come first so the low two bits index the register file
    typedef enum logic [3:0] {
        t_rega, t_regb, t_regc, t_regd,
        t_marlo, t_marhi,
        t_ram,      // Store through the data port
        t_out,      // Output strobe
        t_jump,     // Conditional load of pc
        t_none
    } target_e;

    typedef enum logic [2:0] {
        a_rega, a_regb, a_regc, a_regd,
        a_marlo, a_marhi
    } a_src_e;

    typedef enum logic [2:0] {
        b_rega, b_regb, b_regc, b_regd,
        b_immed, b_ram, b_marlo, b_marhi
    } b_src_e;

    typedef enum logic [3:0] {
        cond_always, cond_c, cond_z, cond_n, cond_o,
        cond_eq, cond_ne, cond_gt, cond_lt
    } cond_e;

    typedef struct packed {
        alu_op_e             alu_op;
        target_e             target;
        a_src_e              a_src;
        b_src_e              b_src;
        cond_e               cond;
        logic                addr_direct;     // Picks direct_addr16 over the MAR when set
        logic [INSTR_W-44:0] spare;
        logic [7:0]          immed8;
        logic [15:0]         direct_addr16;
    } instr_t;

    // All flags active high
    typedef struct packed {
        logic c;
        logic z;
        logic o;
        logic n;
        logic gt;   // Unsigned A above B
        logic lt;
        logic eq;
        logic ne;
    } flags_t;

endpackage
